/* common/adc_pkg.sv */
package adc_pkg;

	////////////////////
	// converter sizes
	////////////////////
	localparam int W_SAMPLE   = 18;                      // result width
	localparam int N_CHAN     = 8;
	localparam int N_PER_LINE = 4;                       // channels per serial line
	localparam int RD_BITS    = W_SAMPLE * N_PER_LINE;   // 72 bits per line per frame
	localparam int MIN_CYCLE  = 200;                     // clk_in cycles, convst to convst
	localparam logic [2:0] OS_MIN = 3'd1;                // lowest oversampling code

	// counter widths
	localparam int CYC_W  = $clog2(MIN_CYCLE + 1);
	localparam int RD_W   = $clog2(RD_BITS);
	localparam int BIT_W  = $clog2(W_SAMPLE);
	localparam int CH_W   = $clog2(N_CHAN);
	localparam int SLOT_W = $clog2(N_PER_LINE);

	////////////////////
	// state machines
	////////////////////
	typedef enum logic [1:0] {CONV_IDLE, CONV_START, CONV_WAIT} conv_state_t;
	typedef enum logic [1:0] {RD_IDLE, RD_SHIFT, RD_DONE} read_state_t;

	typedef struct packed {
		logic convst_n;   // active low, one cycle
		logic cs_n;
		logic sclk;       // idles high
		logic rst;
		logic [2:0] os;
		logic spare;      // tied low
	} adc_pins_t;

	typedef struct packed {
		logic valid;
		logic [SLOT_W-1:0] slot;       // channel within the line
		logic [W_SAMPLE-1:0] data_a;   // line a, channels 0-3
		logic [W_SAMPLE-1:0] data_b;   // line b, channels 4-7
	} pair_t;

endpackage

/* common/apb_pkg.sv */
package apb_pkg;

	////////////////////
	// bus sizes
	////////////////////
	localparam int ADDR_W = 8;
	localparam int DATA_W = 32;

	typedef struct packed {
		logic psel;
		logic penable;                // high in the access cycle
		logic pwrite;
		logic [ADDR_W-1:0] paddr;
		logic [DATA_W-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] prdata;
		logic pready;                 // always high, no wait states
		logic pslverr;
	} apb_rsp_t;

	////////////////////
	// register map
	////////////////////
	localparam logic [ADDR_W-1:0] REG_CTRL    = 8'h00;   // bit 0 run
	localparam logic [ADDR_W-1:0] REG_OS      = 8'h04;   // oversampling code, 3 bits
	localparam logic [ADDR_W-1:0] REG_STATUS  = 8'h08;   // frame count, running
	localparam logic [ADDR_W-1:0] REG_SAMPLE0 = 8'h10;   // channel n at +4n
	localparam logic [ADDR_W-1:0] SAMPLE_SPAN = 8'h20;   // eight words of samples

endpackage

/* adc_ctrl/adc_sequencer.sv */
`timescale 1ns/1ps

module adc_sequencer (
	input  logic clk_in,
	input  logic reset_in,
	input  logic run,                  // from control register
	input  logic [2:0] os_mode,        // already clamped
	input  logic busy,                 // converter busy
	output adc_pkg::adc_pins_t pins,
	output logic shift_strobe          // high on the cycle sclk rises
);

	adc_pkg::conv_state_t conv_state;
	adc_pkg::read_state_t rd_state;
	logic [adc_pkg::CYC_W-1:0] conv_cnt;   // cycles since last convst
	logic [adc_pkg::RD_W-1:0] bit_cnt;     // rising sclk edges this frame
	logic busy_q;                          // for busy edge detect
	logic cs_n_q;
	logic sclk_q;
	logic cycle_done;

	assign cycle_done = (conv_cnt >= adc_pkg::CYC_W'(adc_pkg::MIN_CYCLE));

	////////////////////
	// conversion loop
	////////////////////
	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			conv_state <= adc_pkg::CONV_IDLE;
			conv_cnt <= '0;
		end else begin
			case (conv_state)
				adc_pkg::CONV_IDLE: if (run) conv_state <= adc_pkg::CONV_START;
				adc_pkg::CONV_START: begin
					conv_state <= adc_pkg::CONV_WAIT;
					conv_cnt <= adc_pkg::CYC_W'(1);        // pulse cycle counts as one
				end
				adc_pkg::CONV_WAIT: begin
					if (!cycle_done) conv_cnt <= conv_cnt + 1'b1;   // saturates at min cycle
					// both min cycle and end of conversion before next pulse
					if (cycle_done && !busy)
						conv_state <= run ? adc_pkg::CONV_START : adc_pkg::CONV_IDLE;
				end
				default: conv_state <= adc_pkg::CONV_IDLE;
			endcase
		end
	end

	////////////////////
	// read loop
	////////////////////
	// reads previous results while the current conversion is busy
	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			rd_state <= adc_pkg::RD_IDLE;
			bit_cnt <= '0;
			busy_q <= 1'b0;
			cs_n_q <= 1'b1;
			sclk_q <= 1'b1;
		end else begin
			busy_q <= busy;
			case (rd_state)
				adc_pkg::RD_IDLE: if (busy && !busy_q) begin   // busy rising edge
					rd_state <= adc_pkg::RD_SHIFT;
					cs_n_q <= 1'b0;
					bit_cnt <= '0;
				end
				adc_pkg::RD_SHIFT: begin
					sclk_q <= ~sclk_q;                            // half clk_in rate
					if (!sclk_q) begin                            // rising edge now
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == adc_pkg::RD_W'(adc_pkg::RD_BITS - 1)) begin
							rd_state <= adc_pkg::RD_DONE;
							cs_n_q <= 1'b1;                       // sclk back high too
						end
					end
				end
				adc_pkg::RD_DONE: if (!busy) rd_state <= adc_pkg::RD_IDLE;
				default: rd_state <= adc_pkg::RD_IDLE;
			endcase
		end
	end

	assign shift_strobe = (rd_state == adc_pkg::RD_SHIFT) && !sclk_q;

	assign pins = '{
		convst_n: (conv_state != adc_pkg::CONV_START),
		cs_n:     cs_n_q,
		sclk:     sclk_q,
		rst:      reset_in,      // converter held in reset with us
		os:       os_mode,
		spare:    1'b0
	};

	// convst pulse is a single cycle wide
	a_convst_single: assert property (@(posedge clk_in) disable iff (reset_in)
		!pins.convst_n |=> pins.convst_n);
	// chip select only while shifting
	a_cs_in_shift: assert property (@(posedge clk_in) disable iff (reset_in)
		!pins.cs_n |-> rd_state == adc_pkg::RD_SHIFT);

endmodule

/* adc_ctrl/adc_deserializer.sv */
`timescale 1ns/1ps

module adc_deserializer (
	input  logic clk_in,
	input  logic reset_in,
	input  logic shift_strobe,    // sample both lines now
	input  logic sdata_a,         // channels 0-3
	input  logic sdata_b,         // channels 4-7
	output adc_pkg::pair_t pair
);

	logic [adc_pkg::W_SAMPLE-2:0] sr_a;   // msb-first, last bit joins on output
	logic [adc_pkg::W_SAMPLE-2:0] sr_b;
	logic [adc_pkg::BIT_W-1:0] bit_cnt;
	logic [adc_pkg::SLOT_W-1:0] slot_cnt;
	logic word_end;
	logic valid_q;
	logic [adc_pkg::SLOT_W-1:0] slot_q;
	logic [adc_pkg::W_SAMPLE-1:0] data_a_q;
	logic [adc_pkg::W_SAMPLE-1:0] data_b_q;

	assign word_end = shift_strobe && (bit_cnt == adc_pkg::BIT_W'(adc_pkg::W_SAMPLE - 1));

	// control
	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			bit_cnt <= '0;
			slot_cnt <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= word_end;                  // one cycle after 18th strobe
			if (word_end) begin
				bit_cnt <= '0;
				slot_cnt <= slot_cnt + 1'b1;      // wraps after slot 3
			end else if (shift_strobe) begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	// payload
	always_ff @(posedge clk_in) begin
		if (shift_strobe) begin
			sr_a <= {sr_a[adc_pkg::W_SAMPLE-3:0], sdata_a};
			sr_b <= {sr_b[adc_pkg::W_SAMPLE-3:0], sdata_b};
		end
		if (word_end) begin
			data_a_q <= {sr_a, sdata_a};
			data_b_q <= {sr_b, sdata_b};
			slot_q <= slot_cnt;
		end
	end

	assign pair = '{valid: valid_q, slot: slot_q, data_a: data_a_q, data_b: data_b_q};

	// sclk runs at half rate, so strobes never come back to back
	a_strobe_spacing: assert property (@(posedge clk_in) disable iff (reset_in)
		shift_strobe |=> !shift_strobe);

endmodule

/* source/sample_store.sv */
`timescale 1ns/1ps

module sample_store (
	input  logic clk_in,
	input  logic reset_in,
	input  adc_pkg::pair_t pair,
	output logic signed [adc_pkg::W_SAMPLE-1:0] samples [adc_pkg::N_CHAN],
	output logic [15:0] frame_count    // completed frames, wraps
);

	logic [adc_pkg::CH_W-1:0] ch_a;   // line a channel
	logic [adc_pkg::CH_W-1:0] ch_b;   // line b channel, four up
	logic frame_end;

	assign ch_a = adc_pkg::CH_W'(pair.slot);
	assign ch_b = adc_pkg::CH_W'(pair.slot) + adc_pkg::CH_W'(adc_pkg::N_PER_LINE);
	assign frame_end = pair.valid && (pair.slot == adc_pkg::SLOT_W'(adc_pkg::N_PER_LINE - 1));

	////////////////////
	// latest samples
	////////////////////
	always_ff @(posedge clk_in) begin
		if (pair.valid) begin
			samples[ch_a] <= pair.data_a;
			samples[ch_b] <= pair.data_b;
		end
	end

	// frame counter
	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			frame_count <= '0;
		end else if (frame_end) begin
			frame_count <= frame_count + 1'b1;   // last pair of the frame
		end
	end

endmodule

/* source/adc_regs.sv */
`timescale 1ns/1ps

module adc_regs (
	input  logic clk_in,
	input  logic reset_in,
	input  apb_pkg::apb_req_t req,
	output apb_pkg::apb_rsp_t rsp,
	input  logic signed [adc_pkg::W_SAMPLE-1:0] samples [adc_pkg::N_CHAN],
	input  logic [15:0] frame_count,
	output logic run,
	output logic [2:0] os_mode
);

	logic access;                                  // second cycle of a transfer
	logic [apb_pkg::ADDR_W-1:0] sample_off;
	logic [adc_pkg::CH_W-1:0] sample_idx;
	logic hit_ctrl;
	logic hit_os;
	logic hit_status;
	logic hit_sample;
	logic err;
	logic signed [adc_pkg::W_SAMPLE-1:0] sample_sel;
	logic [apb_pkg::DATA_W-1:0] rdata;

	assign access = req.psel && req.penable;

	////////////////////
	// address decode
	////////////////////
	assign sample_off = req.paddr - apb_pkg::REG_SAMPLE0;
	assign sample_idx = sample_off[adc_pkg::CH_W+1:2];   // word index
	assign hit_ctrl   = (req.paddr == apb_pkg::REG_CTRL);
	assign hit_os     = (req.paddr == apb_pkg::REG_OS);
	assign hit_status = (req.paddr == apb_pkg::REG_STATUS);
	assign hit_sample = (req.paddr >= apb_pkg::REG_SAMPLE0) &&
		(sample_off < apb_pkg::SAMPLE_SPAN) && (req.paddr[1:0] == 2'b00);

	// unmapped, or write to a read-only register
	assign err = !(hit_ctrl || hit_os || hit_status || hit_sample) ||
		(req.pwrite && (hit_status || hit_sample));

	assign sample_sel = samples[sample_idx];

	always_comb begin
		rdata = '0;
		if (hit_ctrl) rdata[0] = run;
		if (hit_os) rdata[2:0] = os_mode;
		if (hit_status) rdata = {15'd0, run, frame_count};
		if (hit_sample)   // sign extend to bus width
			rdata = {{(apb_pkg::DATA_W - adc_pkg::W_SAMPLE){sample_sel[adc_pkg::W_SAMPLE-1]}},
				sample_sel};
	end

	////////////////////
	// writable state
	////////////////////
	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			run <= 1'b0;
			os_mode <= adc_pkg::OS_MIN;
		end else if (access && req.pwrite) begin
			if (hit_ctrl) run <= req.pwdata[0];
			if (hit_os)   // clamp to the lowest legal code
				os_mode <= (req.pwdata[2:0] < adc_pkg::OS_MIN) ? adc_pkg::OS_MIN : req.pwdata[2:0];
		end
	end

	assign rsp = '{
		prdata:  (access && !req.pwrite) ? rdata : '0,   // valid in access cycle
		pready:  1'b1,                                   // never stalls
		pslverr: access && err
	};

endmodule

/* source/adc_top.sv */
`timescale 1ns/1ps

module adc_top (
	input  logic clk_in,
	input  logic reset_in,

	// apb slave
	input  apb_pkg::apb_req_t apb_req,
	output apb_pkg::apb_rsp_t apb_rsp,

	// converter
	input  logic busy,
	input  logic sdata_a,
	input  logic sdata_b,
	output adc_pkg::adc_pins_t adc_pins
);

	logic run;
	logic [2:0] os_mode;
	logic shift_strobe;
	adc_pkg::pair_t pair;
	logic signed [adc_pkg::W_SAMPLE-1:0] samples [adc_pkg::N_CHAN];
	logic [15:0] frame_count;

	////////////////////
	// register block
	////////////////////
	adc_regs i_regs (
		.clk_in      (clk_in),
		.reset_in    (reset_in),
		.req         (apb_req),
		.rsp         (apb_rsp),
		.samples     (samples),
		.frame_count (frame_count),
		.run         (run),
		.os_mode     (os_mode)
	);

	// conversion and read control
	adc_sequencer i_sequencer (
		.clk_in       (clk_in),
		.reset_in     (reset_in),
		.run          (run),
		.os_mode      (os_mode),
		.busy         (busy),
		.pins         (adc_pins),
		.shift_strobe (shift_strobe)
	);

	adc_deserializer i_deserializer (
		.clk_in       (clk_in),
		.reset_in     (reset_in),
		.shift_strobe (shift_strobe),
		.sdata_a      (sdata_a),
		.sdata_b      (sdata_b),
		.pair         (pair)
	);

	sample_store i_store (
		.clk_in      (clk_in),
		.reset_in    (reset_in),
		.pair        (pair),
		.samples     (samples),
		.frame_count (frame_count)
	);

endmodule

/* dv/adc_model.sv */
`timescale 1ns/1ps

module adc_model (
	input  logic clk_in,
	input  adc_pkg::adc_pins_t pins,
	output logic busy,
	output logic sdata_a,               // channels 0-3
	output logic sdata_b                // channels 4-7
);

	logic busy_q = 1'b0;
	logic sdata_a_q = 1'b0;
	logic sdata_b_q = 1'b0;
	int conv_k = 0;                     // convst pulses seen since reset
	int busy_left = 0;                  // cycles of busy still to go
	int bit_idx = 0;                    // bit position in the current read
	int frame_id = 0;                   // conversion whose read is underway

	assign busy = busy_q;
	assign sdata_a = sdata_a_q;
	assign sdata_b = sdata_b_q;

	// result of channel ch for conversion k, zero before the first one
	function automatic logic [adc_pkg::W_SAMPLE-1:0] channel_value(int k, int ch);
		logic [adc_pkg::W_SAMPLE-1:0] v;
		if (k < 1) return '0;
		v = adc_pkg::W_SAMPLE'(k * 1000 + ch * 37);
		if (ch % 2 == 1) v = -v;        // odd channels read negative
		return v;
	endfunction

	////////////////////
	// conversion timing
	////////////////////
	always @(posedge clk_in) begin
		if (pins.rst) begin
			conv_k <= 0;
			busy_q <= 1'b0;
			busy_left <= 0;
		end else if (!pins.convst_n) begin                // start of conversion
			conv_k <= conv_k + 1;
			busy_q <= 1'b1;
			busy_left <= 150 + 20 * int'(pins.os);    // longer with oversampling
		end else if (busy_left > 1) begin
			busy_left <= busy_left - 1;
		end else begin
			busy_left <= 0;
			busy_q <= 1'b0;
		end
	end

	////////////////////
	// serial output
	////////////////////
	// previous frame, msb first, new bit on every falling sclk
	always @(negedge pins.sclk) begin
		logic [adc_pkg::W_SAMPLE-1:0] word_a;
		logic [adc_pkg::W_SAMPLE-1:0] word_b;
		if (!pins.cs_n) begin
			if (frame_id != conv_k) begin                 // first edge of a new read
				frame_id = conv_k;
				bit_idx = 0;
			end
			word_a = channel_value(conv_k - 1, bit_idx / adc_pkg::W_SAMPLE)
				<< (bit_idx % adc_pkg::W_SAMPLE);
			word_b = channel_value(conv_k - 1, bit_idx / adc_pkg::W_SAMPLE + 4)
				<< (bit_idx % adc_pkg::W_SAMPLE);
			sdata_a_q <= word_a[adc_pkg::W_SAMPLE-1];
			sdata_b_q <= word_b[adc_pkg::W_SAMPLE-1];
			bit_idx = bit_idx + 1;
		end
	end

endmodule

/* dv/tb_adc_top.sv */
`timescale 1ns/1ps

module tb_adc_top;

	logic clk_in;
	logic reset_in;
	apb_pkg::apb_req_t apb_req;
	apb_pkg::apb_rsp_t apb_rsp;
	logic busy;
	logic sdata_a;
	logic sdata_b;
	adc_pkg::adc_pins_t adc_pins;

	int errors = 0;                 // failed value checks
	int monitor_errors = 0;         // convst or busy timing wrong
	int timeouts = 0;
	int convst_pulses = 0;
	int since_convst = 0;           // high cycles since the last convst pulse
	logic busy_seen = 1'b0;
	logic convst_was_low = 1'b0;

	adc_top i_dut (
		.clk_in   (clk_in),
		.reset_in (reset_in),
		.apb_req  (apb_req),
		.apb_rsp  (apb_rsp),
		.busy     (busy),
		.sdata_a  (sdata_a),
		.sdata_b  (sdata_b),
		.adc_pins (adc_pins)
	);

	adc_model i_model (
		.clk_in  (clk_in),
		.pins    (adc_pins),
		.busy    (busy),
		.sdata_a (sdata_a),
		.sdata_b (sdata_b)
	);

	initial begin
		clk_in = 1'b0;
		forever #5 clk_in = ~clk_in;   // 100 MHz
	end

	////////////////////
	// busy monitor
	////////////////////
	always @(negedge clk_in) begin
		if (!reset_in) begin
			if (busy && !busy_seen) begin
				assert (convst_was_low) else begin
					monitor_errors++;
					$display("Error at %0t: busy rose without a convst pulse", $time);
				end
			end
			if (!adc_pins.convst_n) begin
				// next conversion only once the last one is over
				assert (!busy) else begin
					monitor_errors++;
					$display("Error at %0t: convst pulse while busy", $time);
				end
				if (convst_pulses > 0) begin
					assert (since_convst >= adc_pkg::MIN_CYCLE) else begin
						monitor_errors++;
						$display("Error at %0t: convst period %0d cycles, minimum %0d",
							$time, since_convst + 1, adc_pkg::MIN_CYCLE + 1);
					end
				end
				convst_pulses++;
				since_convst = 0;
			end else begin
				since_convst++;
			end
		end
		busy_seen = busy;
		convst_was_low = !adc_pins.convst_n;
	end

	task automatic compare_word(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("Error at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
		end
	endtask

	// setup cycle, access cycle, then idle; response read mid access cycle
	task automatic access_reg(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(posedge clk_in);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
		@(posedge clk_in);
		apb_req.penable <= 1'b1;
		@(negedge clk_in);
		rdata = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		compare_word("pready", {31'd0, apb_rsp.pready}, 32'd1);
		@(posedge clk_in);
		apb_req <= '0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk_in);
	endtask

	// sign-extended result of channel ch for conversion conv
	function automatic logic [31:0] expected_sample(int conv, int ch);
		logic [17:0] raw;
		if (conv < 1) return 32'd0;
		raw = 18'(conv * 1000 + ch * 37);
		if (ch % 2 == 1) raw = -raw;
		return {{14{raw[17]}}, raw};
	endfunction

	task automatic probe_error(input logic wr, input logic [7:0] addr, input logic exp_err);
		logic [31:0] rdata;
		logic err;
		access_reg(wr, addr, 32'd5, rdata, err);
		compare_word($sformatf("pslverr at 0x%02h", addr), {31'd0, err}, {31'd0, exp_err});
	endtask

	task automatic wait_frames(input int target, output int count);
		logic [31:0] rdata;
		logic err;
		int polls;
		count = 0;
		polls = 0;
		while (count < target && polls < 1000) begin
			access_reg(1'b0, apb_pkg::REG_STATUS, 32'd0, rdata, err);
			count = int'(rdata[15:0]);
			polls++;
		end
		if (count < target) begin
			timeouts++;
			$display("Timeout at %0t: frame count stuck at %0d, wanted %0d", $time, count, target);
		end
	endtask

	////////////////////
	// directed tests
	////////////////////
	task automatic reset_values();
		logic [31:0] rdata;
		logic err;
		access_reg(1'b0, apb_pkg::REG_CTRL, 32'd0, rdata, err);
		compare_word("CTRL after reset", rdata, 32'd0);
		access_reg(1'b0, apb_pkg::REG_OS, 32'd0, rdata, err);
		compare_word("OS after reset", rdata, 32'd1);
		access_reg(1'b0, apb_pkg::REG_STATUS, 32'd0, rdata, err);
		compare_word("STATUS after reset", rdata, 32'd0);
		@(negedge clk_in);
		compare_word("os pins", {29'd0, adc_pins.os}, 32'd1);
		compare_word("convst_n pin", {31'd0, adc_pins.convst_n}, 32'd1);
		compare_word("cs_n pin", {31'd0, adc_pins.cs_n}, 32'd1);
		compare_word("sclk pin", {31'd0, adc_pins.sclk}, 32'd1);
		compare_word("rst pin", {31'd0, adc_pins.rst}, 32'd0);
		compare_word("spare pin", {31'd0, adc_pins.spare}, 32'd0);
	endtask

	task automatic oversampling_clamp();
		logic [31:0] rdata;
		logic err;
		access_reg(1'b1, apb_pkg::REG_OS, 32'd0, rdata, err);
		access_reg(1'b0, apb_pkg::REG_OS, 32'd0, rdata, err);
		compare_word("OS after writing 0", rdata, 32'd1);       // clamped
		access_reg(1'b1, apb_pkg::REG_OS, 32'd5, rdata, err);
		access_reg(1'b0, apb_pkg::REG_OS, 32'd0, rdata, err);
		compare_word("OS after writing 5", rdata, 32'd5);
		@(negedge clk_in);
		compare_word("os pins", {29'd0, adc_pins.os}, 32'd5);
	endtask

	task automatic bus_errors();
		probe_error(1'b0, 8'h0c, 1'b1);                          // unmapped reads
		probe_error(1'b0, 8'h40, 1'b1);
		probe_error(1'b0, 8'h11, 1'b1);                          // misaligned sample
		probe_error(1'b1, 8'h0c, 1'b1);
		probe_error(1'b1, apb_pkg::REG_STATUS, 1'b1);            // read-only
		probe_error(1'b1, apb_pkg::REG_SAMPLE0 + 8'h1c, 1'b1);
		probe_error(1'b0, apb_pkg::REG_CTRL, 1'b0);
		probe_error(1'b0, apb_pkg::REG_STATUS, 1'b0);
		probe_error(1'b0, apb_pkg::REG_SAMPLE0 + 8'h14, 1'b0);
		probe_error(1'b1, apb_pkg::REG_OS, 1'b0);                // keeps os at 5
	endtask

	// after frame n the store holds conversion n-1
	task automatic sample_readback(input int frames);
		logic [31:0] rdata;
		logic err;
		for (int ch = 0; ch < adc_pkg::N_CHAN; ch++) begin
			access_reg(1'b0, apb_pkg::REG_SAMPLE0 + 8'(4 * ch), 32'd0, rdata, err);
			compare_word($sformatf("sample %0d after frame %0d", ch, frames), rdata,
				expected_sample(frames - 1, ch));
		end
	endtask

	task automatic frame_counting();
		logic [31:0] rdata;
		logic err;
		int count;
		int settled;
		int pulses;
		access_reg(1'b1, apb_pkg::REG_CTRL, 32'd1, rdata, err);  // start the loop
		wait_frames(3, count);
		access_reg(1'b0, apb_pkg::REG_STATUS, 32'd0, rdata, err);
		compare_word("STATUS running", {31'd0, rdata[16]}, 32'd1);
		sample_readback(int'(rdata[15:0]));                      // mid run, before next read
		access_reg(1'b1, apb_pkg::REG_CTRL, 32'd0, rdata, err);  // stop
		idle_cycles(600);                                        // last conversion drains
		access_reg(1'b0, apb_pkg::REG_STATUS, 32'd0, rdata, err);
		compare_word("STATUS running after stop", {31'd0, rdata[16]}, 32'd0);
		settled = int'(rdata[15:0]);
		pulses = convst_pulses;
		idle_cycles(1000);
		access_reg(1'b0, apb_pkg::REG_STATUS, 32'd0, rdata, err);
		compare_word("frame count after stop", {16'd0, rdata[15:0]}, 32'(settled));
		compare_word("convst pulses after stop", 32'(convst_pulses), 32'(pulses));
		sample_readback(settled);
	endtask

	initial begin
		reset_in = 1'b1;
		apb_req = '0;
		repeat (4) @(posedge clk_in);
		reset_in <= 1'b0;
		reset_values();
		oversampling_clamp();
		bus_errors();
		frame_counting();
		$display("%0d check errors, %0d monitor errors, %0d timeouts",
			errors, monitor_errors, timeouts);
		if (errors == 0 && monitor_errors == 0 && timeouts == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* verilog.f */
common/adc_pkg.sv
common/apb_pkg.sv
adc_ctrl/adc_sequencer.sv
adc_ctrl/adc_deserializer.sv
source/sample_store.sv
source/adc_regs.sv
source/adc_top.sv
dv/adc_model.sv
dv/tb_adc_top.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f verilog.f --top-module tb_adc_top \
		-Mdir obj_dir -o sim_adc

run: compile
	./obj_dir/sim_adc > sim.log 2>&1; rc=$$?; cat sim.log; exit $$rc
	@if grep -q "TESTS FAILED" sim.log; then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
